// File: include/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Widths
`define UART_REG_W      8   // One UART register
`define UART_DATA_W     32  // Bus word
`define UART_ADDR_W     32  // Byte address
`define UART_WADDR_W    3   // Register index
`define UART_WADDR_LSB  3   // Registers sit on 64-bit boundaries
`define UART_ID_W       4   // Transaction ID
`define UART_OVERSAMPLE 16  // Baud ticks per serial bit

// Register index with DLAB clear
`define UART_RHR_OFFSET 3'd0  // Read side
`define UART_THR_OFFSET 3'd0  // Write side
`define UART_IER_OFFSET 3'd1
`define UART_ISR_OFFSET 3'd2  // Read side
`define UART_FCR_OFFSET 3'd2  // Write side
`define UART_LCR_OFFSET 3'd3
`define UART_MCR_OFFSET 3'd4
`define UART_LSR_OFFSET 3'd5
`define UART_MSR_OFFSET 3'd6
`define UART_SPR_OFFSET 3'd7

// Register index with DLAB set
`define UART_DLL_OFFSET 3'd0
`define UART_DLM_OFFSET 3'd1

// Reset values and interrupt codes
`define UART_SPR_DEFAULT 8'h5A
`define UART_ISR_NONE    8'h01  // No interrupt pending
`define UART_ISR_RLS     8'h06  // Line status error
`define UART_ISR_RDA     8'h04  // Received data
`define UART_ISR_THRE    8'h02  // Holding register empty

// Bit positions
`define UART_LCR_DLAB 7
`define UART_IER_RDA  0
`define UART_IER_THRE 1
`define UART_IER_RLS  2
`define UART_LSR_DR   0
`define UART_LSR_OE   1
`define UART_LSR_FE   3
`define UART_LSR_THRE 5
`define UART_LSR_TEMT 6

`endif

// File: rtl/uart_baud_gen.sv
`include "uart_defines.svh"

module uart_baud_gen (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  uart_pkg::divisor_t divisor_i,  // {DLM, DLL}
  output logic               baud_tick_o // One pulse per divisor cycles
);

  import uart_pkg::*;

  divisor_t cnt_q;   // Counts down to zero
  divisor_t div_q;   // Divisor the count runs on
  logic     tick_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      div_q  <= '0;
      tick_q <= 1'b0;
    end else if (divisor_i == '0) begin
      cnt_q  <= '0;  // Stopped
      div_q  <= '0;
      tick_q <= 1'b0;
    end else if (divisor_i != div_q) begin
      div_q  <= divisor_i;  // New divisor, restart the period
      cnt_q  <= divisor_i - 1'b1;
      tick_q <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= div_q - 1'b1;  // Reload and tick
      tick_q <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - 1'b1;
      tick_q <= 1'b0;
    end
  end

  assign baud_tick_o = tick_q;

  // No tick after a cycle with the divisor at zero
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (divisor_i == '0) |=> !baud_tick_o);

endmodule

// File: rtl/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register and bus types
  ////////////////////////////////////////////////////////////////////////////

  // One 8-bit UART register
  typedef logic [`UART_REG_W-1:0] uart_reg_t;

  // Bus word, data in the low byte
  typedef logic [`UART_DATA_W-1:0] bus_data_t;

  // Byte address from the host
  typedef logic [`UART_ADDR_W-1:0] bus_addr_t;

  // Register index, address bits 5:3
  typedef logic [`UART_WADDR_W-1:0] word_addr_t;

  // Transaction ID echoed in the response
  typedef logic [`UART_ID_W-1:0] bus_id_t;

  // Divisor latch {DLM, DLL}
  typedef logic [2*`UART_REG_W-1:0] divisor_t;

  // Line status, DR OE FE THRE TEMT live, others zero
  typedef logic [`UART_REG_W-1:0] lsr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Serial side types
  ////////////////////////////////////////////////////////////////////////////

  // Tick count within one bit
  typedef logic [$clog2(`UART_OVERSAMPLE)-1:0] os_cnt_t;

  // Data bit index within one frame
  typedef logic [$clog2(`UART_REG_W)-1:0] bit_idx_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,   // Waiting for a falling edge
    RX_START,  // Checking the start bit at mid-bit
    RX_DATA,   // Shifting in eight data bits
    RX_STOP    // Checking the stop bit
  } rx_state_e;

  // Transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

endpackage

// File: rtl/uart_register.sv
`include "uart_defines.svh"

module uart_register (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Bus request
  input  logic                      req_i,
  input  uart_pkg::bus_addr_t       addr_i,
  input  logic                      we_i,
  input  logic [`UART_DATA_W/8-1:0] be_i,
  input  uart_pkg::bus_data_t       wdata_i,
  input  uart_pkg::bus_id_t         aid_i,
  // Bus response
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output uart_pkg::bus_data_t       rdata_o,
  output uart_pkg::bus_id_t         rid_o,
  output logic                      err_o,
  output logic                      irq_o,
  // Baud generator
  output uart_pkg::divisor_t        divisor_o,
  // Receiver
  input  uart_pkg::uart_reg_t       rx_data_i,
  input  logic                      rx_valid_i,
  input  logic                      rx_frame_err_i,
  // Transmitter
  output uart_pkg::uart_reg_t       tx_data_o,
  output logic                      tx_load_o,
  input  logic                      tx_busy_i
);

  import uart_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  word_addr_t waddr;
  uart_reg_t  wr_byte;
  logic       dlab, wr_en, rd_en;
  logic       thr_we, ier_we, fcr_we, lcr_we, mcr_we, spr_we, dll_we, dlm_we;
  logic       rhr_rd, lsr_rd;   // Reads with side effects
  logic       wr_err, rd_err;
  uart_reg_t  rd_data;

  // Registers and status
  uart_reg_t ier_q, fcr_q, lcr_q, mcr_q, spr_q, dll_q, dlm_q;
  uart_reg_t thr_q, rhr_q;
  logic      dr_q, oe_q, fe_q, thre_q;
  lsr_t      lsr;
  uart_reg_t isr;

  // Response stage
  logic      rvalid_q, err_q, irq_q;
  bus_id_t   rid_q;
  uart_reg_t rdata_q;

  assign waddr   = addr_i[`UART_WADDR_LSB +: `UART_WADDR_W];
  assign wr_byte = wdata_i[`UART_REG_W-1:0];
  assign dlab    = lcr_q[`UART_LCR_DLAB];
  assign wr_en   = req_i & we_i & be_i[0];  // Low byte lane only
  assign rd_en   = req_i & ~we_i;

  // Write decode, LCR stays reachable so DLAB can be cleared again
  always_comb begin
    {thr_we, ier_we, fcr_we, lcr_we, mcr_we, spr_we, dll_we, dlm_we} = '0;
    wr_err = 1'b0;
    if (wr_en && !dlab) begin
      case (waddr)
        `UART_THR_OFFSET: thr_we = 1'b1;
        `UART_IER_OFFSET: ier_we = 1'b1;
        `UART_FCR_OFFSET: fcr_we = 1'b1;
        `UART_LCR_OFFSET: lcr_we = 1'b1;
        `UART_MCR_OFFSET: mcr_we = 1'b1;
        `UART_SPR_OFFSET: spr_we = 1'b1;
        default:          wr_err = 1'b1;  // LSR, MSR read only
      endcase
    end else if (wr_en) begin
      case (waddr)
        `UART_DLL_OFFSET: dll_we = 1'b1;
        `UART_DLM_OFFSET: dlm_we = 1'b1;
        `UART_LCR_OFFSET: lcr_we = 1'b1;
        default:          wr_err = 1'b1;
      endcase
    end
  end

  // Read decode, value as of the accepting edge
  always_comb begin
    rd_data = '0;
    rd_err  = 1'b0;
    rhr_rd  = 1'b0;
    lsr_rd  = 1'b0;
    if (!dlab) begin
      case (waddr)
        `UART_RHR_OFFSET: begin
          rd_data = rhr_q;
          rhr_rd  = rd_en;
        end
        `UART_IER_OFFSET: rd_data = ier_q;
        `UART_ISR_OFFSET: rd_data = isr;
        `UART_LCR_OFFSET: rd_data = lcr_q;
        `UART_MCR_OFFSET: rd_data = mcr_q;
        `UART_LSR_OFFSET: begin
          rd_data = lsr;
          lsr_rd  = rd_en;
        end
        `UART_MSR_OFFSET: rd_data = '0;  // No modem lines
        `UART_SPR_OFFSET: rd_data = spr_q;
      endcase
    end else begin
      case (waddr)
        `UART_DLL_OFFSET: rd_data = dll_q;
        `UART_DLM_OFFSET: rd_data = dlm_q;
        `UART_LCR_OFFSET: rd_data = lcr_q;
        default:          rd_err  = rd_en;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Line status and interrupt identification
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    lsr                 = '0;
    lsr[`UART_LSR_DR]   = dr_q;
    lsr[`UART_LSR_OE]   = oe_q;
    lsr[`UART_LSR_FE]   = fe_q;
    lsr[`UART_LSR_THRE] = thre_q;
    lsr[`UART_LSR_TEMT] = thre_q & ~tx_busy_i;  // Nothing left to shift
  end

  // Highest priority first
  always_comb begin
    if ((oe_q | fe_q) & ier_q[`UART_IER_RLS])   isr = `UART_ISR_RLS;
    else if (dr_q & ier_q[`UART_IER_RDA])       isr = `UART_ISR_RDA;
    else if (thre_q & ier_q[`UART_IER_THRE])    isr = `UART_ISR_THRE;
    else                                        isr = `UART_ISR_NONE;
    isr[7:6] = {2{fcr_q[0]}};  // FIFO enable echo as on a 16550
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ier_q    <= '0;
      fcr_q    <= '0;
      lcr_q    <= '0;
      mcr_q    <= '0;
      dll_q    <= '0;
      dlm_q    <= '0;
      spr_q    <= `UART_SPR_DEFAULT;
      dr_q     <= 1'b0;
      oe_q     <= 1'b0;
      fe_q     <= 1'b0;
      thre_q   <= 1'b1;
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      irq_q    <= 1'b0;
    end else begin
      if (ier_we) ier_q <= wr_byte;
      if (fcr_we) fcr_q <= wr_byte;  // Kept, no FIFOs behind it
      if (lcr_we) lcr_q <= wr_byte;
      if (mcr_we) mcr_q <= wr_byte;
      if (dll_we) dll_q <= wr_byte;
      if (dlm_we) dlm_q <= wr_byte;
      if (spr_we) spr_q <= `UART_SPR_DEFAULT;  // Write restores default
      // New byte wins over a clearing read
      if (rx_valid_i)                  dr_q <= 1'b1;
      else if (rhr_rd)                 dr_q <= 1'b0;
      if (rx_valid_i & dr_q)           oe_q <= 1'b1;  // Unread byte lost
      else if (lsr_rd)                 oe_q <= 1'b0;
      if (rx_valid_i & rx_frame_err_i) fe_q <= 1'b1;
      else if (lsr_rd)                 fe_q <= 1'b0;
      if (thr_we)                      thre_q <= 1'b0;  // Fresh byte pending
      else if (tx_load_o)              thre_q <= 1'b1;
      rvalid_q <= req_i;
      err_q    <= wr_err | rd_err;
      irq_q    <= ~isr[0];
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (thr_we)     thr_q <= wr_byte;
    if (rx_valid_i) rhr_q <= rx_data_i;
    rid_q   <= aid_i;
    rdata_q <= rd_en ? rd_data : '0;
  end

  assign gnt_o     = req_i;  // Always ready
  assign rvalid_o  = rvalid_q;
  assign rid_o     = rid_q;
  assign err_o     = err_q;
  assign rdata_o   = {{(`UART_DATA_W - `UART_REG_W){1'b0}}, rdata_q};
  assign irq_o     = irq_q;
  assign divisor_o = {dlm_q, dll_q};
  assign tx_data_o = thr_q;
  assign tx_load_o = ~thre_q & ~tx_busy_i;  // Hand over when shifter idle

  // Response one cycle after every request
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ##1 (rvalid_o == $past(req_i)));

  // Transmitter never reloaded mid-frame, busy follows each load at once
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tx_load_o |=> (tx_busy_i && !tx_load_o));

endmodule

// File: rtl/uart_rx.sv
`include "uart_defines.svh"

module uart_rx (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                baud_tick_i,    // 16x bit rate
  input  logic                rx_i,           // Serial line, async
  output uart_pkg::uart_reg_t rx_data_o,
  output logic                rx_valid_o,     // Pulse at mid stop bit
  output logic                rx_frame_err_o  // Stop bit was low
);

  import uart_pkg::*;

  localparam os_cnt_t BitLast  = os_cnt_t'(`UART_OVERSAMPLE - 1);
  localparam os_cnt_t HalfLast = os_cnt_t'(`UART_OVERSAMPLE / 2 - 1);

  logic      rx_meta_q, rx_sync_q;  // Two-flop synchronizer
  rx_state_e state_q;
  os_cnt_t   cnt_q;
  bit_idx_t  bit_q;
  uart_reg_t shift_q;
  logic      valid_q, ferr_q;
  logic      bit_end, half_end, sample_en;

  assign bit_end   = baud_tick_i & (cnt_q == BitLast);   // Mid of next bit
  assign half_end  = baud_tick_i & (cnt_q == HalfLast);  // Mid of start bit
  assign sample_en = (state_q == RX_DATA) & bit_end;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta_q <= 1'b1;  // Line idles high
      rx_sync_q <= 1'b1;
      state_q   <= RX_IDLE;
      cnt_q     <= '0;
      bit_q     <= '0;
      valid_q   <= 1'b0;
      ferr_q    <= 1'b0;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      valid_q   <= 1'b0;
      ferr_q    <= 1'b0;
      if (baud_tick_i) cnt_q <= cnt_q + 1'b1;
      unique case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_sync_q) state_q <= RX_START;  // Falling edge
        end
        RX_START: begin
          if (half_end) begin
            cnt_q   <= '0;  // Realign on mid-bit
            bit_q   <= '0;
            state_q <= rx_sync_q ? RX_IDLE : RX_DATA;  // Glitch, not a start
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == bit_idx_t'(`UART_REG_W - 1)) state_q <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            valid_q <= 1'b1;
            ferr_q  <= ~rx_sync_q;  // Stop must be high
            state_q <= RX_IDLE;
          end
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // Data shift, LSB arrives first
  always_ff @(posedge clk_i) begin
    if (sample_en) shift_q <= {rx_sync_q, shift_q[`UART_REG_W-1:1]};
  end

  assign rx_data_o      = shift_q;
  assign rx_valid_o     = valid_q;
  assign rx_frame_err_o = ferr_q;

  // Each byte is handed over exactly once
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rx_valid_o |=> !rx_valid_o);

endmodule

// File: rtl/uart_top.sv
`include "uart_defines.svh"

module uart_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Bus
  input  logic                      req_i,
  input  uart_pkg::bus_addr_t       addr_i,
  input  logic                      we_i,
  input  logic [`UART_DATA_W/8-1:0] be_i,
  input  uart_pkg::bus_data_t       wdata_i,
  input  uart_pkg::bus_id_t         aid_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output uart_pkg::bus_data_t       rdata_o,
  output uart_pkg::bus_id_t         rid_o,
  output logic                      err_o,
  output logic                      irq_o,
  // Serial pins
  input  logic                      rx_i,
  output logic                      tx_o
);

  import uart_pkg::*;

  divisor_t  divisor;
  logic      baud_tick;
  uart_reg_t rx_data;
  logic      rx_valid, rx_frame_err;
  uart_reg_t tx_data;
  logic      tx_load, tx_busy;

  // Shared 16x tick
  uart_baud_gen i_baud_gen (
    .clk_i, .arst_n_i,
    .divisor_i   (divisor),
    .baud_tick_o (baud_tick)
  );

  // Input side
  uart_rx i_rx (
    .clk_i, .arst_n_i,
    .baud_tick_i    (baud_tick),
    .rx_i,
    .rx_data_o      (rx_data),
    .rx_valid_o     (rx_valid),
    .rx_frame_err_o (rx_frame_err)
  );

  // Register map and status
  uart_register i_register (
    .clk_i, .arst_n_i,
    .req_i, .addr_i, .we_i, .be_i, .wdata_i, .aid_i,
    .gnt_o, .rvalid_o, .rdata_o, .rid_o, .err_o, .irq_o,
    .divisor_o      (divisor),
    .rx_data_i      (rx_data),
    .rx_valid_i     (rx_valid),
    .rx_frame_err_i (rx_frame_err),
    .tx_data_o      (tx_data),
    .tx_load_o      (tx_load),
    .tx_busy_i      (tx_busy)
  );

  // Output side
  uart_tx i_tx (
    .clk_i, .arst_n_i,
    .baud_tick_i (baud_tick),
    .tx_data_i   (tx_data),
    .tx_load_i   (tx_load),
    .tx_busy_o   (tx_busy),
    .tx_o
  );

endmodule

// File: rtl/uart_tx.sv
`include "uart_defines.svh"

module uart_tx (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                baud_tick_i,  // 16x bit rate
  input  uart_pkg::uart_reg_t tx_data_i,
  input  logic                tx_load_i,    // Only while idle
  output logic                tx_busy_o,
  output logic                tx_o          // Serial line
);

  import uart_pkg::*;

  localparam os_cnt_t BitLast = os_cnt_t'(`UART_OVERSAMPLE - 1);

  tx_state_e state_q, state_d;
  os_cnt_t   cnt_q, cnt_d;
  bit_idx_t  bit_q, bit_d;
  uart_reg_t shift_q, shift_d;
  logic      tx_q;
  logic      bit_end;

  assign bit_end = baud_tick_i & (cnt_q == BitLast);

  // Next state
  always_comb begin
    state_d = state_q;
    cnt_d   = baud_tick_i ? cnt_q + 1'b1 : cnt_q;
    bit_d   = bit_q;
    shift_d = shift_q;
    unique case (state_q)
      TX_IDLE: begin
        cnt_d = '0;
        if (tx_load_i) begin
          shift_d = tx_data_i;  // Latch the byte
          bit_d   = '0;
          state_d = TX_START;
        end
      end
      TX_START: if (bit_end) state_d = TX_DATA;
      TX_DATA: begin
        if (bit_end) begin
          shift_d = shift_q >> 1;  // LSB first
          bit_d   = bit_q + 1'b1;
          if (bit_q == bit_idx_t'(`UART_REG_W - 1)) state_d = TX_STOP;
        end
      end
      TX_STOP: if (bit_end) state_d = TX_IDLE;
      default: state_d = TX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= TX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;  // Idle line high
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      bit_q   <= bit_d;
      // Registered line level, no decode glitches
      tx_q    <= (state_d == TX_DATA) ? shift_d[0] : (state_d != TX_START);
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q <= shift_d;
  end

  assign tx_busy_o = (state_q != TX_IDLE);  // Through end of stop bit
  assign tx_o      = tx_q;

  // Register block waits for the shifter
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tx_load_i |-> (state_q == TX_IDLE));

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the UART testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1

rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sim.f --top-module tb_uart --Mdir obj_dir -o tb_uart_sim > build.log 2>&1 &&
./obj_dir/tb_uart_sim > sim.log 2>&1

grep -q "^TESTBENCH PASSED$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim.f
+incdir+include
rtl/uart_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_rx.sv
rtl/uart_register.sv
rtl/uart_tx.sv
rtl/uart_top.sv
test/tb_clk_gen.sv
test/tb_uart.sv

// File: test/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period  = 2;  // 4 ns clock
  localparam int reset_cycles = 4;

  initial begin
    clk_o = 1'b0;
    forever #half_period clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// File: test/tb_uart.sv
`include "uart_defines.svh"

module tb_uart;

  timeunit 1ns;
  timeprecision 100ps;

  import uart_pkg::*;

  localparam logic [31:0] seed        = 32'hf33d_e992;
  localparam int          lsr_polls   = 1000;  // Two frames fit easily
  localparam int          irq_cycles  = 1000;
  localparam int          rst_cycles  = 20;
  localparam uart_reg_t   lsr_idle    = 8'h60;  // THRE and TEMT
  localparam uart_reg_t   isr_none    = 8'h01;

  typedef enum logic [2:0] {
    OP_WR,        // Write, all byte lanes
    OP_WR_NOBE,   // Write with lane 0 off
    OP_RD,        // Read, compare data and error
    OP_WAIT_LSR,  // Poll LSR until mask bits set
    OP_WAIT_IRQ,  // Wait for irq_o level
    OP_IRQ        // Compare irq_o now
  } op_e;

  typedef struct packed {
    op_e        op;
    word_addr_t idx;
    uart_reg_t  wdata;
    uart_reg_t  exp_data;
    logic       exp_err;
  } row_t;

  logic      clk, arst_n;
  logic      req, we, gnt, rvalid, rsp_err, irq, line;
  logic [3:0] be;
  bus_addr_t addr;
  bus_data_t wdata, rdata;
  bus_id_t   aid, rid;
  row_t      rows[$];

  tb_clk_gen i_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  uart_top dut (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .req_i    (req),
    .addr_i   (addr),
    .we_i     (we),
    .be_i     (be),
    .wdata_i  (wdata),
    .aid_i    (aid),
    .gnt_o    (gnt),
    .rvalid_o (rvalid),
    .rdata_o  (rdata),
    .rid_o    (rid),
    .err_o    (rsp_err),
    .irq_o    (irq),
    .rx_i     (line),  // Loopback
    .tx_o     (line)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("error at time %0t: %s", $time, msg));
  endtask

  task automatic check_data(input uart_reg_t got, input uart_reg_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s data 0x%02h, expected 0x%02h", what, got, exp));
  endtask

  task automatic check_err(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s err_o %b, expected %b", what, got, exp));
  endtask

  task automatic check_irq(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s irq_o %b, expected %b", what, got, exp));
  endtask

  task automatic check_id(input bus_id_t got, input bus_id_t exp, input string what);
    if (got !== exp)
      report_mismatch($sformatf("%s rid_o 0x%0h, expected 0x%0h", what, got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////////////////////////////////////////

  // One request, response expected exactly one cycle later
  task automatic run_transfer(input logic wr, input word_addr_t idx, input uart_reg_t wbyte,
                              input logic [3:0] lanes, output uart_reg_t rbyte,
                              output logic rerr);
    bus_id_t id;
    id = bus_id_t'($urandom);
    @(posedge clk);
    req   <= 1'b1;
    we    <= wr;
    addr  <= bus_addr_t'(idx) << `UART_WADDR_LSB;
    be    <= lanes;
    wdata <= {24'($urandom), wbyte};  // Upper lanes carry noise
    aid   <= id;
    @(negedge clk);
    if (gnt !== 1'b1) abort_run("gnt_o was low while a request was presented");
    if (rvalid !== 1'b0) abort_run("rvalid_o was high before the request was accepted");
    @(posedge clk);  // Accepting edge
    req <= 1'b0;
    we  <= 1'b0;
    be  <= 4'h0;
    @(negedge clk);
    if (rvalid !== 1'b1) abort_run("rvalid_o did not rise one cycle after the request");
    check_id(rid, id, "response");
    if (rdata[31:8] !== 24'h0) abort_run("read data above bit 7 was not zero");
    rbyte = rdata[7:0];
    rerr  = rsp_err;
  endtask

  task automatic bus_write(input word_addr_t idx, input uart_reg_t data,
                           input logic [3:0] lanes, output logic rerr);
    uart_reg_t unused;
    run_transfer(1'b1, idx, data, lanes, unused, rerr);
  endtask

  task automatic bus_read(input word_addr_t idx, output uart_reg_t data, output logic rerr);
    run_transfer(1'b0, idx, 8'h00, 4'hF, data, rerr);
  endtask

  // Poll LSR until every mask bit is set
  task automatic wait_lsr(input uart_reg_t mask);
    uart_reg_t lsr;
    logic      e;
    int        polls;
    bus_read(`UART_LSR_OFFSET, lsr, e);
    check_err(e, 1'b0, "LSR poll");
    polls = 1;
    while (((lsr & mask) != mask) && (polls < lsr_polls)) begin
      bus_read(`UART_LSR_OFFSET, lsr, e);
      check_err(e, 1'b0, "LSR poll");
      polls++;
    end
    if ((lsr & mask) != mask)
      abort_run($sformatf("timeout while waiting for LSR bits 0x%02h", mask));
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while ((irq !== level) && (n < irq_cycles)) begin
      @(negedge clk);
      n++;
    end
    if (irq !== level)
      abort_run($sformatf("timeout while waiting for irq_o to become %b", level));
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while ((arst_n !== 1'b1) && (n < rst_cycles)) begin
      @(posedge clk);
      n++;
    end
    if (arst_n !== 1'b1) abort_run("timeout while waiting for reset release");
  endtask

  task automatic add_row(input op_e op, input word_addr_t idx, input uart_reg_t wd,
                         input uart_reg_t exp_d, input logic exp_e);
    rows.push_back('{op: op, idx: idx, wdata: wd, exp_data: exp_d, exp_err: exp_e});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    row_t      row;
    uart_reg_t rbyte, b0, b1, b2, b3;
    logic      rerr;
    req   = 1'b0;
    we    = 1'b0;
    be    = 4'h0;
    addr  = '0;
    wdata = '0;
    aid   = '0;
    void'($urandom(seed));
    b0 = uart_reg_t'($urandom);
    b1 = uart_reg_t'($urandom);
    b2 = uart_reg_t'($urandom);
    b3 = uart_reg_t'($urandom);

    // Reset values
    add_row(OP_RD, `UART_LSR_OFFSET, 8'h00, lsr_idle, 1'b0);
    add_row(OP_RD, `UART_ISR_OFFSET, 8'h00, isr_none, 1'b0);
    add_row(OP_RD, `UART_SPR_OFFSET, 8'h00, 8'h5A, 1'b0);
    add_row(OP_RD, `UART_LCR_OFFSET, 8'h00, 8'h00, 1'b0);
    add_row(OP_RD, `UART_IER_OFFSET, 8'h00, 8'h00, 1'b0);
    // DLAB decode, IER marked so it differs from DLM
    add_row(OP_WR, `UART_IER_OFFSET, 8'h08, 8'h00, 1'b0);
    add_row(OP_WR, `UART_LCR_OFFSET, 8'h80, 8'h00, 1'b0);
    add_row(OP_WR, `UART_DLL_OFFSET, 8'h02, 8'h00, 1'b0);
    add_row(OP_WR, `UART_DLM_OFFSET, 8'h00, 8'h00, 1'b0);
    add_row(OP_RD, `UART_DLL_OFFSET, 8'h00, 8'h02, 1'b0);
    add_row(OP_RD, `UART_DLM_OFFSET, 8'h00, 8'h00, 1'b0);
    add_row(OP_RD, 3'd5, 8'h00, 8'h00, 1'b1);  // Unmapped under DLAB
    add_row(OP_RD, `UART_LCR_OFFSET, 8'h00, 8'h80, 1'b0);
    add_row(OP_WR, `UART_LCR_OFFSET, 8'h00, 8'h00, 1'b0);
    add_row(OP_RD, `UART_IER_OFFSET, 8'h00, 8'h08, 1'b0);
    // Error and byte-enable rules
    add_row(OP_WR, `UART_MSR_OFFSET, 8'h00, 8'h00, 1'b1);
    add_row(OP_WR_NOBE, `UART_IER_OFFSET, 8'hFF, 8'h00, 1'b0);
    add_row(OP_RD, `UART_IER_OFFSET, 8'h00, 8'h08, 1'b0);
    add_row(OP_WR, `UART_SPR_OFFSET, 8'h33, 8'h00, 1'b0);
    add_row(OP_RD, `UART_SPR_OFFSET, 8'h00, 8'h5A, 1'b0);
    add_row(OP_WR, `UART_IER_OFFSET, 8'h00, 8'h00, 1'b0);
    // Loopback
    add_row(OP_WR, `UART_THR_OFFSET, b0, 8'h00, 1'b0);
    add_row(OP_WAIT_LSR, 3'd0, 8'h01, 8'h00, 1'b0);  // DR
    add_row(OP_RD, `UART_RHR_OFFSET, 8'h00, b0, 1'b0);
    add_row(OP_WAIT_LSR, 3'd0, 8'h60, 8'h00, 1'b0);  // Stop bit done
    add_row(OP_RD, `UART_LSR_OFFSET, 8'h00, lsr_idle, 1'b0);
    // Index 0 is DLL under DLAB and RHR again once it clears
    add_row(OP_WR, `UART_LCR_OFFSET, 8'h80, 8'h00, 1'b0);
    add_row(OP_RD, `UART_DLL_OFFSET, 8'h00, 8'h02, 1'b0);
    add_row(OP_WR, `UART_LCR_OFFSET, 8'h00, 8'h00, 1'b0);
    add_row(OP_RD, `UART_RHR_OFFSET, 8'h00, b0, 1'b0);
    // Interrupts
    add_row(OP_WR, `UART_IER_OFFSET, 8'h01, 8'h00, 1'b0);
    add_row(OP_IRQ, 3'd0, 8'h00, 8'h00, 1'b0);
    add_row(OP_WR, `UART_THR_OFFSET, b1, 8'h00, 1'b0);
    add_row(OP_WAIT_IRQ, 3'd0, 8'h01, 8'h00, 1'b0);
    add_row(OP_RD, `UART_ISR_OFFSET, 8'h00, 8'h04, 1'b0);  // Received data
    add_row(OP_RD, `UART_RHR_OFFSET, 8'h00, b1, 1'b0);
    add_row(OP_WAIT_IRQ, 3'd0, 8'h00, 8'h00, 1'b0);
    add_row(OP_RD, `UART_ISR_OFFSET, 8'h00, isr_none, 1'b0);
    add_row(OP_WR, `UART_IER_OFFSET, 8'h02, 8'h00, 1'b0);
    add_row(OP_WAIT_LSR, 3'd0, 8'h60, 8'h00, 1'b0);
    add_row(OP_WAIT_IRQ, 3'd0, 8'h01, 8'h00, 1'b0);
    add_row(OP_RD, `UART_ISR_OFFSET, 8'h00, 8'h02, 1'b0);  // THR empty
    add_row(OP_WR, `UART_IER_OFFSET, 8'h00, 8'h00, 1'b0);
    // Overrun, the poll that ends the wait sees OE
    add_row(OP_WR, `UART_THR_OFFSET, b2, 8'h00, 1'b0);
    add_row(OP_WR, `UART_THR_OFFSET, b3, 8'h00, 1'b0);
    add_row(OP_WAIT_LSR, 3'd0, 8'h03, 8'h00, 1'b0);
    add_row(OP_RD, `UART_RHR_OFFSET, 8'h00, b3, 1'b0);
    add_row(OP_WAIT_LSR, 3'd0, 8'h60, 8'h00, 1'b0);
    add_row(OP_RD, `UART_LSR_OFFSET, 8'h00, lsr_idle, 1'b0);  // OE gone

    wait_reset_release();
    foreach (rows[i]) begin
      row = rows[i];
      case (row.op)
        OP_WR: begin
          bus_write(row.idx, row.wdata, 4'hF, rerr);
          check_err(rerr, row.exp_err, $sformatf("row %0d write", i));
        end
        OP_WR_NOBE: begin
          bus_write(row.idx, row.wdata, 4'hE, rerr);
          check_err(rerr, row.exp_err, $sformatf("row %0d write", i));
        end
        OP_RD: begin
          bus_read(row.idx, rbyte, rerr);
          check_err(rerr, row.exp_err, $sformatf("row %0d read", i));
          check_data(rbyte, row.exp_data, $sformatf("row %0d read", i));
        end
        OP_WAIT_LSR: wait_lsr(row.wdata);
        OP_WAIT_IRQ: wait_irq(row.wdata[0]);
        default:     check_irq(irq, row.wdata[0], $sformatf("row %0d", i));
      endcase
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule
